// ==== filelist.f ====
+incdir+tb
logic/noc_pkg.sv
logic/noc_input_port.sv
logic/noc_output_arbiter.sv
logic/noc_router.sv
logic/noc_mesh_top.sv
tb/tb_noc_mesh.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the mesh testbench with verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_noc_mesh -f filelist.f > sim.log 2>&1 \
  && ./obj_dir/Vtb_noc_mesh >> sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tb/tb_noc_model.svh ====
`ifndef TB_NOC_MODEL_SVH
`define TB_NOC_MODEL_SVH

// node that a header flit addresses, n = x * NOC_DIM_Y + y
function automatic int dest_node(input noc_flit_t hdr);
  return int'(hdr[NOC_ADDR_X_LSB +: NOC_ADDR_W]) * NOC_DIM_Y +
         int'(hdr[NOC_ADDR_Y_LSB +: NOC_ADDR_W]);
endfunction

// flit idx of a packet: 0 header, 1 length, then payload
// source and sequence ride in the upper bits that routing ignores
function automatic noc_flit_t packet_flit(input int src, input int dst, input int seq,
                                          input int len, input int idx);
  noc_flit_t flit;
  flit        = '0;
  flit[31:24] = 8'(src);
  flit[23:16] = 8'(seq);
  if (idx == 0) begin
    flit[NOC_ADDR_X_LSB +: NOC_ADDR_W] = NOC_ADDR_W'(dst / NOC_DIM_Y);
    flit[NOC_ADDR_Y_LSB +: NOC_ADDR_W] = NOC_ADDR_W'(dst % NOC_DIM_Y);
  end else if (idx == 1) begin
    flit[15:0] = 16'(len);
  end else begin
    flit[15:0] = {8'hd0, 8'(idx - 2)};
  end
  return flit;
endfunction

task automatic compare_flit(input noc_flit_t got, input noc_flit_t exp, input string what);
  if (got !== exp) begin
    mismatch_errs++;
    $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic compare_count(input int got, input int exp, input string what);
  if (got != exp) begin
    mismatch_errs++;
    $display("MISMATCH at %0t: %s, got %0d expected %0d", $time, what, got, exp);
  end
endtask

`endif

// ==== tb/tb_noc_mesh.sv ====
`timescale 1ns/1ps

module tb_noc_mesh
  import noc_pkg::*;
();

  localparam int NOC_DIM_X    = 2;
  localparam int NOC_DIM_Y    = 2;
  localparam int BUFFER_DEPTH = 4;
  localparam int NODES        = NOC_DIM_X * NOC_DIM_Y;

  logic                  clock_i;
  logic                  arst_n_i;
  logic      [NODES-1:0] local_tx_i;
  noc_flit_t [NODES-1:0] local_data_i;
  logic      [NODES-1:0] local_credit_o;
  logic      [NODES-1:0] local_tx_o;
  noc_flit_t [NODES-1:0] local_data_o;
  logic      [NODES-1:0] local_credit_i;

  // sender side
  noc_flit_t send_q [NODES][$];
  int        tx_credit [NODES];
  int        seq_no [NODES];
  // expected flits per destination and source, index dst * NODES + src
  noc_flit_t exp_q [NODES*NODES][$];
  int        exp_cnt [NODES];
  int        recv_cnt [NODES];
  int        rx_pending [NODES];
  int        mon_left [NODES];
  int        mon_src [NODES];
  int        held_flits [NODES];
  bit        hold_credit [NODES];
  int        mismatch_errs;
  int        timeout_errs;
  int        other_errs;
  int        seed;

  `include "tb_noc_model.svh"

  noc_mesh_top #(
    .NOC_DIM_X   (NOC_DIM_X),
    .NOC_DIM_Y   (NOC_DIM_Y),
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) u_dut (
    .clock_i       (clock_i),
    .arst_n_i      (arst_n_i),
    .local_tx_i    (local_tx_i),
    .local_data_i  (local_data_i),
    .local_credit_o(local_credit_o),
    .local_tx_o    (local_tx_o),
    .local_data_o  (local_data_o),
    .local_credit_i(local_credit_i)
  );

  initial begin
    clock_i = 1'b0;
    forever #20 clock_i = ~clock_i;
  end

  // local senders, one flit per cycle while tokens last
  always @(negedge clock_i) begin : b_send
    for (int n = 0; n < NODES; n++) begin
      local_tx_i[n] <= 1'b0;
      if (!arst_n_i) begin
        tx_credit[n] = BUFFER_DEPTH;
      end else begin
        if (tx_credit[n] > 0 && send_q[n].size() > 0) begin
          local_tx_i[n]   <= 1'b1;
          local_data_i[n] <= send_q[n].pop_front();
          tx_credit[n]--;
        end
        // a returned token is usable from the next cycle
        if (local_credit_o[n]) begin
          tx_credit[n]++;
        end
      end
    end
  end

  // local receivers with packet monitor
  always @(negedge clock_i) begin : b_receive
    noc_flit_t flit;
    int        k;
    for (int n = 0; n < NODES; n++) begin
      local_credit_i[n] <= 1'b0;
      if (!arst_n_i) begin
        rx_pending[n] = 0;
        mon_left[n]   = 0;
      end else begin
        if (local_tx_o[n]) begin
          flit = local_data_o[n];
          rx_pending[n]++;
          if (hold_credit[n]) begin
            held_flits[n]++;
          end
          if (mon_left[n] == 0) begin
            mon_src[n] = int'(flit[31:24]);
            k          = n * NODES + mon_src[n];
            if (mon_src[n] >= NODES) begin
              other_errs++;
              $display("header %h at node %0d names no known source", flit, n);
            end else if (exp_q[k].size() < 2) begin
              other_errs++;
              $display("packet from node %0d reached node %0d but none was sent there",
                       mon_src[n], n);
            end else begin
              compare_flit(flit, exp_q[k].pop_front(), "header flit");
              compare_count(dest_node(flit), n, "node that delivered the header");
              // body length comes from the expected length flit
              mon_left[n] = 1 + int'(exp_q[k][0][15:0]);
              recv_cnt[n]++;
            end
          end else begin
            k = n * NODES + mon_src[n];
            if (exp_q[k].size() == 0) begin
              other_errs++;
              $display("extra flit %h at node %0d", flit, n);
            end else begin
              compare_flit(flit, exp_q[k].pop_front(), "length or payload flit");
            end
            mon_left[n]--;
          end
        end
        if (!hold_credit[n] && rx_pending[n] > 0) begin
          local_credit_i[n] <= 1'b1;
          rx_pending[n]--;
        end
      end
    end
  end

  task automatic send_packet(input int src, input int dst, input int len);
    noc_flit_t flit;
    int        k;
    k = 0;
    for (int idx = 0; idx < len + 2; idx++) begin
      flit = packet_flit(src, dst, seq_no[src], len, idx);
      if (idx == 0) begin
        k = dest_node(flit) * NODES + src;
        exp_cnt[dest_node(flit)]++;
      end
      send_q[src].push_back(flit);
      exp_q[k].push_back(flit);
    end
    seq_no[src] = (seq_no[src] + 1) % 256;
  endtask

  task automatic wait_drained(input int limit, input string what);
    int cycles;
    bit busy;
    cycles = 0;
    busy   = 1'b1;
    while (busy && cycles < limit) begin
      @(posedge clock_i);
      cycles++;
      busy = 1'b0;
      for (int n = 0; n < NODES; n++) begin
        if (send_q[n].size() != 0 || mon_left[n] != 0 || rx_pending[n] != 0) begin
          busy = 1'b1;
        end
      end
      for (int k = 0; k < NODES * NODES; k++) begin
        if (exp_q[k].size() != 0) begin
          busy = 1'b1;
        end
      end
    end
    if (busy) begin
      timeout_errs++;
      $display("timeout waiting for %s", what);
    end
  endtask

  task automatic check_totals(input string what);
    for (int n = 0; n < NODES; n++) begin
      compare_count(recv_cnt[n], exp_cnt[n], $sformatf("%s, packets at node %0d", what, n));
    end
    for (int k = 0; k < NODES * NODES; k++) begin
      compare_count(exp_q[k].size(), 0, $sformatf("%s, flits left for pair %0d", what, k));
    end
  endtask

  initial begin : b_main
    int src;
    int dst;
    seed           = 32'h48df6bf0;
    mismatch_errs  = 0;
    timeout_errs   = 0;
    other_errs     = 0;
    local_tx_i     <= '0;
    local_data_i   <= '0;
    local_credit_i <= '0;
    arst_n_i       = 1'b0;
    repeat (5) @(posedge clock_i);
    @(negedge clock_i);
    arst_n_i = 1'b1;

    // quiet outputs with no traffic
    for (int c = 0; c < 8; c++) begin
      @(negedge clock_i);
      compare_count($countones(local_tx_o), 0, "local_tx_o bits high while idle");
      compare_count($countones(local_credit_o), 0, "local_credit_o bits high while idle");
    end

    @(posedge clock_i);
    for (int s = 0; s < NODES; s++) begin
      for (int d = 0; d < NODES; d++) begin
        send_packet(s, d, 1 + (s + d) % 3);
      end
    end
    wait_drained(500, "all-pairs packets");
    check_totals("all pairs");

    // zero length and 12 flit bodies, order kept per pair
    @(posedge clock_i);
    send_packet(1, 2, 0);
    send_packet(1, 2, 12);
    send_packet(1, 2, 0);
    send_packet(1, 2, 5);
    send_packet(1, 2, 12);
    send_packet(3, 0, 12);
    send_packet(3, 0, 0);
    send_packet(0, 0, 0);
    wait_drained(500, "short and long packets");
    check_totals("length mix");

    // everyone sends to node 3 at once
    @(posedge clock_i);
    for (int r = 0; r < 3; r++) begin
      for (int s = 0; s < NODES; s++) begin
        send_packet(s, 3, 4);
      end
    end
    wait_drained(800, "contention at node 3");
    check_totals("contention");

    // node 1 withholds its tokens for a while
    @(posedge clock_i);
    held_flits[1]  = 0;
    hold_credit[1] = 1'b1;
    send_packet(0, 1, 5);
    send_packet(2, 1, 5);
    send_packet(3, 1, 3);
    repeat (40) @(posedge clock_i);
    compare_count(held_flits[1], BUFFER_DEPTH, "flits at node 1 while tokens held");
    hold_credit[1] = 1'b0;
    wait_drained(500, "back-pressure drain at node 1");
    check_totals("back-pressure");

    @(posedge clock_i);
    for (int p = 0; p < 200; p++) begin
      src = $unsigned($random(seed)) % NODES;
      dst = $unsigned($random(seed)) % NODES;
      send_packet(src, dst, $unsigned($random(seed)) % 7);
    end
    wait_drained(8000, "random traffic");
    check_totals("random traffic");

    $display("errors: %0d mismatches, %0d timeouts, %0d other", mismatch_errs,
             timeout_errs, other_errs);
    if (mismatch_errs + timeout_errs + other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== logic/noc_mesh_top.sv ====
`timescale 1ns/1ps

module noc_mesh_top
  import noc_pkg::*;
#(
  parameter int NOC_DIM_X    = 2,
  parameter int NOC_DIM_Y    = 2,
  parameter int BUFFER_DEPTH = 4
) (
  input  logic                                  clock_i,
  input  logic                                  arst_n_i,
  input  logic      [NOC_DIM_X*NOC_DIM_Y-1:0]   local_tx_i,
  input  noc_flit_t [NOC_DIM_X*NOC_DIM_Y-1:0]   local_data_i,
  output logic      [NOC_DIM_X*NOC_DIM_Y-1:0]   local_credit_o,
  output logic      [NOC_DIM_X*NOC_DIM_Y-1:0]   local_tx_o,
  output noc_flit_t [NOC_DIM_X*NOC_DIM_Y-1:0]   local_data_o,
  input  logic      [NOC_DIM_X*NOC_DIM_Y-1:0]   local_credit_i
);

  localparam int NODES = NOC_DIM_X * NOC_DIM_Y;

  // per node link bundles, node n = x * NOC_DIM_Y + y
  wire       [NOC_PORTS-1:0] rx_w   [NODES];
  wire noc_flit_t [NOC_PORTS-1:0] din_w [NODES];
  wire       [NOC_PORTS-1:0] cin_w  [NODES];
  logic      [NOC_PORTS-1:0] tx_w   [NODES];
  noc_flit_t [NOC_PORTS-1:0] dout_w [NODES];
  logic      [NOC_PORTS-1:0] cout_w [NODES];

  for (genvar i = 0; i < NOC_DIM_X; i++) begin : g_x
    for (genvar j = 0; j < NOC_DIM_Y; j++) begin : g_y
      localparam int N = i * NOC_DIM_Y + j;

      noc_router #(
        .BUFFER_DEPTH(BUFFER_DEPTH),
        .ROUTER_X    (i),
        .ROUTER_Y    (j)
      ) u_router (
        .clock_i (clock_i),
        .arst_n_i(arst_n_i),
        .rx_i    (rx_w[N]),
        .data_i  (din_w[N]),
        .credit_o(cout_w[N]),
        .tx_o    (tx_w[N]),
        .data_o  (dout_w[N]),
        .credit_i(cin_w[N])
      );

      // local port goes straight to the top level
      assign rx_w[N][LOCAL]    = local_tx_i[N];
      assign din_w[N][LOCAL]   = local_data_i[N];
      assign cin_w[N][LOCAL]   = local_credit_i[N];
      assign local_tx_o[N]     = tx_w[N][LOCAL];
      assign local_data_o[N]   = dout_w[N][LOCAL];
      assign local_credit_o[N] = cout_w[N][LOCAL];

      // x axis
      if (i == 0) begin : g_west_border
        assign rx_w[N][WEST]  = 1'b0;
        assign din_w[N][WEST] = '0;
        assign cin_w[N][WEST] = 1'b0;
      end else begin : g_west_link
        assign rx_w[N][WEST]  = tx_w[N-NOC_DIM_Y][EAST];
        assign din_w[N][WEST] = dout_w[N-NOC_DIM_Y][EAST];
        assign cin_w[N][WEST] = cout_w[N-NOC_DIM_Y][EAST];
      end

      if (i == NOC_DIM_X - 1) begin : g_east_border
        assign rx_w[N][EAST]  = 1'b0;
        assign din_w[N][EAST] = '0;
        assign cin_w[N][EAST] = 1'b0;
      end else begin : g_east_link
        assign rx_w[N][EAST]  = tx_w[N+NOC_DIM_Y][WEST];
        assign din_w[N][EAST] = dout_w[N+NOC_DIM_Y][WEST];
        assign cin_w[N][EAST] = cout_w[N+NOC_DIM_Y][WEST];
      end

      // y axis, north is y + 1
      if (j == 0) begin : g_south_border
        assign rx_w[N][SOUTH]  = 1'b0;
        assign din_w[N][SOUTH] = '0;
        assign cin_w[N][SOUTH] = 1'b0;
      end else begin : g_south_link
        assign rx_w[N][SOUTH]  = tx_w[N-1][NORTH];
        assign din_w[N][SOUTH] = dout_w[N-1][NORTH];
        assign cin_w[N][SOUTH] = cout_w[N-1][NORTH];
      end

      if (j == NOC_DIM_Y - 1) begin : g_north_border
        assign rx_w[N][NORTH]  = 1'b0;
        assign din_w[N][NORTH] = '0;
        assign cin_w[N][NORTH] = 1'b0;
      end else begin : g_north_link
        assign rx_w[N][NORTH]  = tx_w[N+1][SOUTH];
        assign din_w[N][NORTH] = dout_w[N+1][SOUTH];
        assign cin_w[N][NORTH] = cout_w[N+1][SOUTH];
      end
    end
  end

endmodule

// ==== logic/noc_router.sv ====
`timescale 1ns/1ps

module noc_router
  import noc_pkg::*;
#(
  parameter int BUFFER_DEPTH = 4,
  parameter int ROUTER_X     = 0,
  parameter int ROUTER_Y     = 0
) (
  input  logic                            clock_i,
  input  logic                            arst_n_i,
  input  logic      [NOC_PORTS-1:0]       rx_i,
  input  noc_flit_t [NOC_PORTS-1:0]       data_i,
  output logic      [NOC_PORTS-1:0]       credit_o,
  output logic      [NOC_PORTS-1:0]       tx_o,
  output noc_flit_t [NOC_PORTS-1:0]       data_o,
  input  logic      [NOC_PORTS-1:0]       credit_i
);

  logic      [NOC_PORTS-1:0] head_valid;
  logic      [NOC_PORTS-1:0] head_last;
  logic      [NOC_PORTS-1:0] in_pop;
  logic      [NOC_PORTS-1:0] out_pop;
  noc_flit_t [NOC_PORTS-1:0] head_data;
  noc_flit_t [NOC_PORTS-1:0] out_data;
  noc_port_e                 route [NOC_PORTS];
  logic      [NOC_PORTS-1:0] req   [NOC_PORTS];
  logic      [NOC_PORTS-1:0] grant [NOC_PORTS];

  for (genvar p = 0; p < NOC_PORTS; p++) begin : g_port
    noc_input_port #(
      .BUFFER_DEPTH(BUFFER_DEPTH),
      .ROUTER_X    (ROUTER_X),
      .ROUTER_Y    (ROUTER_Y)
    ) u_in (
      .clock_i     (clock_i),
      .arst_n_i    (arst_n_i),
      .rx_i        (rx_i[p]),
      .data_i      (data_i[p]),
      .credit_o    (credit_o[p]),
      .pop_i       (in_pop[p]),
      .head_valid_o(head_valid[p]),
      .head_data_o (head_data[p]),
      .route_o     (route[p]),
      .last_o      (head_last[p])
    );

    noc_output_arbiter #(
      .BUFFER_DEPTH(BUFFER_DEPTH)
    ) u_arb (
      .clock_i (clock_i),
      .arst_n_i(arst_n_i),
      .req_i   (req[p]),
      .last_i  (head_last),
      .grant_o (grant[p]),
      .pop_o   (out_pop[p]),
      .data_i  (out_data[p]),
      .tx_o    (tx_o[p]),
      .data_o  (data_o[p]),
      .credit_i(credit_i[p])
    );
  end

  // request matrix, req[out][in]
  always_comb begin
    for (int o = 0; o < NOC_PORTS; o++) begin
      for (int i = 0; i < NOC_PORTS; i++) begin
        req[o][i] = head_valid[i] && (route[i] == noc_port_e'(o));
      end
    end
  end

  // crossbar, grants are one-hot per output
  always_comb begin
    for (int o = 0; o < NOC_PORTS; o++) begin
      out_data[o] = '0;
      for (int i = 0; i < NOC_PORTS; i++) begin
        if (grant[o][i]) begin
          out_data[o] = head_data[i];
        end
      end
    end
  end

  // an input is popped by whichever output actually sent its head
  always_comb begin
    for (int i = 0; i < NOC_PORTS; i++) begin
      in_pop[i] = 1'b0;
      for (int o = 0; o < NOC_PORTS; o++) begin
        in_pop[i] = in_pop[i] | (grant[o][i] & out_pop[o]);
      end
    end
  end

endmodule

// ==== logic/noc_output_arbiter.sv ====
`timescale 1ns/1ps

module noc_output_arbiter
  import noc_pkg::*;
#(
  parameter int BUFFER_DEPTH = 4
) (
  input  logic                 clock_i,
  input  logic                 arst_n_i,
  input  logic [NOC_PORTS-1:0] req_i,
  input  logic [NOC_PORTS-1:0] last_i,
  output logic [NOC_PORTS-1:0] grant_o,
  output logic                 pop_o,
  input  noc_flit_t            data_i,
  output logic                 tx_o,
  output noc_flit_t            data_o,
  input  logic                 credit_i
);

  localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);
  localparam int IDX_W = $clog2(NOC_PORTS);

  logic [CNT_W-1:0]     credit_cnt_q;
  logic                 locked_q;
  logic [NOC_PORTS-1:0] grant_q;
  logic [NOC_PORTS-1:0] grant_rr;
  logic [IDX_W-1:0]     rr_ptr_q;
  logic [IDX_W-1:0]     grant_idx;
  logic                 has_credit;

  // round robin, search starts just after the last winner
  always_comb begin
    int cand;
    grant_rr  = '0;
    grant_idx = rr_ptr_q;
    cand      = 0;
    // descending scan so the nearest requester is written last and wins
    for (int k = NOC_PORTS; k >= 1; k--) begin
      cand = (int'(rr_ptr_q) + k) % NOC_PORTS;
      if (req_i[cand]) begin
        grant_rr       = '0;
        grant_rr[cand] = 1'b1;
        grant_idx      = IDX_W'(cand);
      end
    end
  end

  // a packet keeps its link from header to last flit
  assign grant_o    = locked_q ? grant_q : grant_rr;
  assign has_credit = (credit_cnt_q != '0);
  assign pop_o      = has_credit && |(grant_o & req_i);

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locked_q <= 1'b0;
      grant_q  <= '0;
      rr_ptr_q <= '0;
    end else if (pop_o) begin
      grant_q  <= grant_o;
      locked_q <= !(|(grant_o & last_i));
      if (!locked_q) begin
        rr_ptr_q <= grant_idx;
      end
    end
  end

  // tokens for the downstream buffer
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_cnt_q <= CNT_W'(BUFFER_DEPTH);
    end else begin
      case ({pop_o, credit_i})
        2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
        2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
        default: credit_cnt_q <= credit_cnt_q;
      endcase
    end
  end

  // link register
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_o <= 1'b0;
    end else begin
      tx_o <= pop_o;
    end
  end

  always_ff @(posedge clock_i) begin
    if (pop_o) begin
      data_o <= data_i;
    end
  end

  // downstream only returns tokens for flits it was actually sent
  a_credit_bound: assert property (
    @(posedge clock_i) disable iff (!arst_n_i) credit_i |-> credit_cnt_q != CNT_W'(BUFFER_DEPTH)
  ) else $error("credit returned with no flit outstanding");

endmodule

// ==== logic/noc_input_port.sv ====
`timescale 1ns/1ps

module noc_input_port
  import noc_pkg::*;
#(
  parameter int BUFFER_DEPTH = 4,
  parameter int ROUTER_X     = 0,
  parameter int ROUTER_Y     = 0
) (
  input  logic      clock_i,
  input  logic      arst_n_i,
  input  logic      rx_i,
  input  noc_flit_t data_i,
  output logic      credit_o,
  input  logic      pop_i,
  output logic      head_valid_o,
  output noc_flit_t head_data_o,
  output noc_port_e route_o,
  output logic      last_o
);

  localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);
  // payload count field of the length flit, upper bits are ignored
  localparam int LEN_W = 16;

  noc_flit_t             fifo_mem [BUFFER_DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      fill_q;
  logic                  fifo_full;
  noc_in_state_e         state_q;
  logic [LEN_W-1:0]      remain_q;
  logic [LEN_W-1:0]      head_len;
  logic [NOC_ADDR_W-1:0] dest_x;
  logic [NOC_ADDR_W-1:0] dest_y;
  noc_port_e             head_route;
  noc_port_e             route_q;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // buffer storage
  always_ff @(posedge clock_i) begin
    if (rx_i) begin
      fifo_mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (rx_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({rx_i, pop_i})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  assign fifo_full    = (fill_q == CNT_W'(BUFFER_DEPTH));
  assign head_valid_o = (fill_q != '0);
  assign head_data_o  = fifo_mem[rd_ptr_q];
  // one token back upstream for every flit leaving the buffer
  assign credit_o     = pop_i;

  // xy routing, x first
  assign dest_x   = head_data_o[NOC_ADDR_X_LSB +: NOC_ADDR_W];
  assign dest_y   = head_data_o[NOC_ADDR_Y_LSB +: NOC_ADDR_W];
  assign head_len = head_data_o[LEN_W-1:0];

  always_comb begin
    if (dest_x > NOC_ADDR_W'(ROUTER_X)) begin
      head_route = EAST;
    end else if (dest_x < NOC_ADDR_W'(ROUTER_X)) begin
      head_route = WEST;
    end else if (dest_y > NOC_ADDR_W'(ROUTER_Y)) begin
      head_route = NORTH;
    end else if (dest_y < NOC_ADDR_W'(ROUTER_Y)) begin
      head_route = SOUTH;
    end else begin
      head_route = LOCAL;
    end
  end

  // header decides directly, later flits follow the latched route
  assign route_o = (state_q == ST_HEADER) ? head_route : route_q;
  assign last_o  = ((state_q == ST_LENGTH) && (head_len == '0)) ||
                   ((state_q == ST_PAYLOAD) && (remain_q == LEN_W'(1)));

  // packet phase, advanced once per popped flit
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= ST_HEADER;
      remain_q <= '0;
      route_q  <= LOCAL;
    end else if (pop_i) begin
      case (state_q)
        ST_HEADER: begin
          route_q <= head_route;
          state_q <= ST_LENGTH;
        end
        ST_LENGTH: begin
          remain_q <= head_len;
          state_q  <= (head_len == '0) ? ST_HEADER : ST_PAYLOAD;
        end
        default: begin
          remain_q <= remain_q - 1'b1;
          if (remain_q == LEN_W'(1)) begin
            state_q <= ST_HEADER;
          end
        end
      endcase
    end
  end

  // the upstream credit counter must keep writes out of a full buffer
  a_no_overflow: assert property (
    @(posedge clock_i) disable iff (!arst_n_i) rx_i |-> !fifo_full
  ) else $error("input port (%0d,%0d) written while full", ROUTER_X, ROUTER_Y);

endmodule

// ==== logic/noc_pkg.sv ====
package noc_pkg;

  // one flit on every link; the header layout below assumes 32 bits
  typedef logic [31:0] noc_flit_t;

  // router ports per node
  localparam int NOC_PORTS = 5;

  // port index, shared by routers, mesh wiring and the testbench
  typedef enum logic [2:0] {
    EAST  = 3'd0,
    WEST  = 3'd1,
    NORTH = 3'd2,
    SOUTH = 3'd3,
    LOCAL = 3'd4
  } noc_port_e;

  // phase of the flit currently at the head of an input buffer
  typedef enum logic [1:0] {
    ST_HEADER,
    ST_LENGTH,
    ST_PAYLOAD
  } noc_in_state_e;

  // header flit fields
  // |31 ........ 16|15 .... 8|7 ..... 0|
  // |   unused     |  dest x |  dest y |
  localparam int NOC_ADDR_X_LSB = 8;
  localparam int NOC_ADDR_Y_LSB = 0;
  localparam int NOC_ADDR_W     = 8;

endpackage
